//--- rtl/isa_pkg.sv
package isa_pkg;

    // ==================================================
    // Instruction fields
    // ==================================================
    localparam int XLEN_INST = 32;
    localparam int ARCH_REGS = 32;
    localparam int AREG_W    = $clog2(ARCH_REGS);
    localparam int OPC_W     = 7;
    localparam int FUNCT3_W  = 3;
    localparam int OP_W      = 4;      // ALU and LSU ops share one width.

    typedef logic [XLEN_INST-1:0] inst_t;
    typedef logic [AREG_W-1:0]    arch_reg_t;
    typedef logic [31:0]          imm_t;
    typedef logic [OPC_W-1:0]     opcode_t;
    typedef logic [FUNCT3_W-1:0]  funct3_t;

    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;

    // ==================================================
    // Routing and operations
    // ==================================================
    typedef enum logic [1:0] {
        UNIT_NONE = 2'd0,
        UNIT_ALU  = 2'd1,
        UNIT_LSU  = 2'd2
    } unit_e;

    typedef enum logic [OP_W-1:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    // Store flag on top of funct3.
    typedef enum logic [OP_W-1:0] {
        LSU_LB  = 4'b0000,
        LSU_LH  = 4'b0001,
        LSU_LW  = 4'b0010,
        LSU_LBU = 4'b0100,
        LSU_LHU = 4'b0101,
        LSU_SB  = 4'b1000,
        LSU_SH  = 4'b1001,
        LSU_SW  = 4'b1010
    } lsu_op_e;

    typedef struct packed {
        unit_e     unit;
        alu_op_e   alu_op;
        lsu_op_e   lsu_op;
        logic      uses_imm;
        imm_t      imm;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
        logic      rd_en;
        logic      illegal;
    } dec_inst_t;

endpackage : isa_pkg

//--- rtl/core_pkg.sv
package core_pkg;
    import isa_pkg::*;

    // ==================================================
    // Pipeline sizes
    // ==================================================
    localparam int DEC_PARAL = 2;
    localparam int PHYS_REGS = 64;
    localparam int PREG_W    = $clog2(PHYS_REGS);
    localparam int FREE_INIT = PHYS_REGS - ARCH_REGS;   // Registers 32 to 63.
    localparam int FL_PTR_W  = $clog2(FREE_INIT);
    localparam int FL_CNT_W  = FL_PTR_W + 1;

    typedef logic [PREG_W-1:0]   phys_reg_t;
    typedef logic [31:0]         pc_t;
    typedef logic [FL_CNT_W-1:0] fl_cnt_t;

    // ==================================================
    // Packets
    // ==================================================
    typedef struct packed {
        pc_t                          pc;       // Packet base.
        inst_t [DEC_PARAL-1:0]        inst;
        logic [DEC_PARAL-1:0]         avail;
    } fetch_pkt_t;

    // Rename result of one slot.
    typedef struct packed {
        phys_reg_t rs1;
        phys_reg_t rs2;
        phys_reg_t rd;
        phys_reg_t old_rd;
    } ren_t;

    typedef struct packed {
        logic [OP_W-1:0] op;            // alu_op_e or lsu_op_e.
        imm_t            imm;
        logic            uses_imm;
        phys_reg_t       rs1;
        phys_reg_t       rs2;
        phys_reg_t       rd;
        logic            rd_en;
    } uop_t;

    typedef struct packed {
        logic [DEC_PARAL-1:0] mask;
        uop_t [DEC_PARAL-1:0] uop;
    } issue_pkt_t;

    typedef struct packed {
        pc_t       pc;
        arch_reg_t rd;
        phys_reg_t prd;
        phys_reg_t old_prd;
        logic      rd_en;
        logic      excp;
    } rob_entry_t;

    typedef struct packed {
        logic [DEC_PARAL-1:0]       mask;
        rob_entry_t [DEC_PARAL-1:0] entry;
    } rob_pkt_t;

    typedef struct packed {
        logic      vld;
        phys_reg_t old_prd;
    } commit_t;

endpackage : core_pkg

//--- rtl/inst_decoder.sv
`timescale 1ns/10ps
module inst_decoder import isa_pkg::*; (
    input  inst_t     inst_i,
    output dec_inst_t dec_o
);
    opcode_t opcode;
    funct3_t funct3;
    logic    f7_b5;
    imm_t    imm_i_type;
    imm_t    imm_s_type;
    alu_op_e alu_op;

    assign opcode     = inst_i[6:0];
    assign funct3     = inst_i[14:12];
    assign f7_b5      = inst_i[30];
    assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s_type = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};

    // Bit 30 selects SUB (register form only) and SRA.
    always_comb begin
        case (funct3)
            3'b000:  alu_op = (f7_b5 && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = f7_b5 ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
    end

    always_comb begin
        dec_o        = '0;
        dec_o.alu_op = alu_op;
        dec_o.lsu_op = lsu_op_e'({opcode == OPC_STORE, funct3});
        dec_o.rs1    = inst_i[19:15];
        case (opcode)
            OPC_OP: begin
                dec_o.unit = UNIT_ALU;
                dec_o.rs2  = inst_i[24:20];
                dec_o.rd   = inst_i[11:7];
            end
            OPC_OP_IMM: begin
                dec_o.unit     = UNIT_ALU;
                dec_o.uses_imm = 1'b1;
                dec_o.imm      = imm_i_type;
                dec_o.rd       = inst_i[11:7];
            end
            OPC_LOAD: begin
                dec_o.unit     = UNIT_LSU;
                dec_o.uses_imm = 1'b1;
                dec_o.imm      = imm_i_type;
                dec_o.rd       = inst_i[11:7];
            end
            OPC_STORE: begin
                dec_o.unit     = UNIT_LSU;
                dec_o.uses_imm = 1'b1;
                dec_o.imm      = imm_s_type;
                dec_o.rs2      = inst_i[24:20];
            end
            default: begin
                dec_o.illegal = 1'b1;                // Goes to the ROB only.
                dec_o.rs1     = '0;
            end
        endcase
        dec_o.rd_en = (dec_o.rd != '0);              // x0 never allocates.
    end

endmodule : inst_decoder

//--- rtl/rename_map.sv
`timescale 1ns/10ps
module rename_map import isa_pkg::*, core_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  dec_inst_t [DEC_PARAL-1:0] dec_i,
    input  logic [DEC_PARAL-1:0]      act_i,
    output phys_reg_t [DEC_PARAL-1:0] phys_rs1_o,
    output phys_reg_t [DEC_PARAL-1:0] phys_rs2_o,
    output phys_reg_t [DEC_PARAL-1:0] old_rd_o,
    input  phys_reg_t [DEC_PARAL-1:0] new_rd_i
);
    phys_reg_t            map_q [ARCH_REGS];
    logic [DEC_PARAL-1:0] wr_en;

    always_comb begin
        for (int s = 0; s < DEC_PARAL; s++) begin
            wr_en[s] = act_i[s] && dec_i[s].rd_en;
        end
    end

    // Table lookup, then bypass from older slots of the same packet.
    always_comb begin
        for (int s = 0; s < DEC_PARAL; s++) begin
            phys_rs1_o[s] = map_q[dec_i[s].rs1];
            phys_rs2_o[s] = map_q[dec_i[s].rs2];
            old_rd_o[s]   = map_q[dec_i[s].rd];
            for (int o = 0; o < s; o++) begin
                if (wr_en[o] && dec_i[o].rd == dec_i[s].rs1) begin
                    phys_rs1_o[s] = new_rd_i[o];
                end
                if (wr_en[o] && dec_i[o].rd == dec_i[s].rs2) begin
                    phys_rs2_o[s] = new_rd_i[o];
                end
                if (wr_en[o] && dec_i[o].rd == dec_i[s].rd) begin
                    old_rd_o[s] = new_rd_i[o];
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= phys_reg_t'(i);          // Identity map.
            end
        end else begin
            for (int s = 0; s < DEC_PARAL; s++) begin
                if (wr_en[s]) begin
                    map_q[dec_i[s].rd] <= new_rd_i[s]; // Younger slot wins.
                end
            end
        end
    end

    for (genvar s = 0; s < DEC_PARAL; s++) begin : g_chk
        a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            wr_en[s] |-> dec_i[s].rd != '0);
    end

endmodule : rename_map

//--- rtl/free_list.sv
`timescale 1ns/10ps
module free_list import core_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic [DEC_PARAL-1:0]      pop_i,
    output phys_reg_t [DEC_PARAL-1:0] pop_idx_o,
    output fl_cnt_t                   count_o,
    input  commit_t                   commit_i
);
    phys_reg_t             fifo_q [FREE_INIT];
    logic [FL_PTR_W-1:0]   head_q;
    logic [FL_PTR_W-1:0]   tail_q;
    fl_cnt_t               count_q;
    fl_cnt_t               n_pop;
    fl_cnt_t               n_push;

    assign n_pop  = fl_cnt_t'(pop_i[0]) + fl_cnt_t'(pop_i[1]);
    assign n_push = fl_cnt_t'(commit_i.vld);

    // Slot 1 takes the head when slot 0 is idle.
    assign pop_idx_o[0] = fifo_q[head_q];
    assign pop_idx_o[1] = pop_i[0] ? fifo_q[head_q + 1'b1] : fifo_q[head_q];
    assign count_o      = count_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= fl_cnt_t'(FREE_INIT);
            for (int i = 0; i < FREE_INIT; i++) begin
                fifo_q[i] <= phys_reg_t'(PHYS_REGS - FREE_INIT + i);
            end
        end else begin
            head_q  <= head_q + n_pop[FL_PTR_W-1:0];
            count_q <= count_q + n_push - n_pop;
            if (commit_i.vld) begin
                fifo_q[tail_q] <= commit_i.old_prd;
                tail_q         <= tail_q + 1'b1;
            end
        end
    end

    // ==================================================
    // Checks
    // ==================================================
    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        n_pop <= count_q);

    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        commit_i.vld |-> (count_q + n_push) <= (fl_cnt_t'(FREE_INIT) + n_pop));

endmodule : free_list

//--- rtl/dispatch_ctrl.sv
`timescale 1ns/10ps
module dispatch_ctrl import isa_pkg::*, core_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  dec_inst_t [DEC_PARAL-1:0] id1_dec_i,
    input  ren_t [DEC_PARAL-1:0]      id1_phys_i,
    input  pc_t                       id1_pc_i,
    input  logic [DEC_PARAL-1:0]      id1_mask_i,
    input  logic                      id1_full_i,
    output issue_pkt_t                alu_pkt_o,
    output issue_pkt_t                lsu_pkt_o,
    output rob_pkt_t                  rob_pkt_o,
    output logic                      alu_vld_o,
    output logic                      lsu_vld_o,
    output logic                      rob_vld_o,
    input  logic                      alu_rdy_i,
    input  logic                      lsu_rdy_i,
    input  logic                      rob_rdy_i,
    output logic                      depart_o
);
    logic need_alu;
    logic need_lsu;
    logic need_rob;
    logic ok_alu;
    logic ok_lsu;
    logic ok_rob;

    function automatic uop_t make_uop(dec_inst_t d, ren_t r, logic [OP_W-1:0] op);
        uop_t u;
        u.op       = op;
        u.imm      = d.imm;
        u.uses_imm = d.uses_imm;
        u.rs1      = r.rs1;
        u.rs2      = r.rs2;
        u.rd       = r.rd;
        u.rd_en    = d.rd_en;
        return u;
    endfunction

    always_comb begin
        for (int s = 0; s < DEC_PARAL; s++) begin
            alu_pkt_o.mask[s] = id1_mask_i[s] && (id1_dec_i[s].unit == UNIT_ALU);
            lsu_pkt_o.mask[s] = id1_mask_i[s] && (id1_dec_i[s].unit == UNIT_LSU);
            alu_pkt_o.uop[s]  = make_uop(id1_dec_i[s], id1_phys_i[s], id1_dec_i[s].alu_op);
            lsu_pkt_o.uop[s]  = make_uop(id1_dec_i[s], id1_phys_i[s], id1_dec_i[s].lsu_op);

            rob_pkt_o.mask[s]          = id1_mask_i[s];   // Every valid slot.
            rob_pkt_o.entry[s].pc      = id1_pc_i + pc_t'(4 * s);
            rob_pkt_o.entry[s].rd      = id1_dec_i[s].rd;
            rob_pkt_o.entry[s].prd     = id1_phys_i[s].rd;
            rob_pkt_o.entry[s].old_prd = id1_phys_i[s].old_rd;
            rob_pkt_o.entry[s].rd_en   = id1_dec_i[s].rd_en;
            rob_pkt_o.entry[s].excp    = id1_dec_i[s].illegal;
        end
    end

    // ==================================================
    // Handshake
    // ==================================================
    assign need_alu = id1_full_i && (|alu_pkt_o.mask);
    assign need_lsu = id1_full_i && (|lsu_pkt_o.mask);
    assign need_rob = id1_full_i && (|id1_mask_i);

    assign ok_alu = !need_alu || alu_rdy_i;
    assign ok_lsu = !need_lsu || lsu_rdy_i;
    assign ok_rob = !need_rob || rob_rdy_i;

    // A vld waits on the other targets, never on its own rdy.
    assign alu_vld_o = need_alu && ok_lsu && ok_rob;
    assign lsu_vld_o = need_lsu && ok_alu && ok_rob;
    assign rob_vld_o = need_rob && ok_alu && ok_lsu;

    assign depart_o = id1_full_i && ok_alu && ok_lsu && ok_rob;

    a_alu_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        alu_vld_o && !alu_rdy_i |=> $stable(alu_pkt_o));

    a_lsu_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        lsu_vld_o && !lsu_rdy_i |=> $stable(lsu_pkt_o));

    a_rob_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rob_vld_o && !rob_rdy_i |=> $stable(rob_pkt_o));

endmodule : dispatch_ctrl

//--- rtl/decode_stage.sv
`timescale 1ns/10ps
module decode_stage import isa_pkg::*, core_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  fetch_pkt_t fetch_pkt_i,
    input  logic       fetch_vld_i,
    output logic       fetch_rdy_o,
    output issue_pkt_t alu_pkt_o,
    output logic       alu_vld_o,
    input  logic       alu_rdy_i,
    output issue_pkt_t lsu_pkt_o,
    output logic       lsu_vld_o,
    input  logic       lsu_rdy_i,
    output rob_pkt_t   rob_pkt_o,
    output logic       rob_vld_o,
    input  logic       rob_rdy_i,
    input  commit_t    commit_i
);
    dec_inst_t [DEC_PARAL-1:0] dec_id0;
    logic [DEC_PARAL-1:0]      act_id0;
    logic [DEC_PARAL-1:0]      pop_id0;
    phys_reg_t [DEC_PARAL-1:0] new_rd_id0;
    phys_reg_t [DEC_PARAL-1:0] rs1_id0;
    phys_reg_t [DEC_PARAL-1:0] rs2_id0;
    phys_reg_t [DEC_PARAL-1:0] old_rd_id0;
    ren_t [DEC_PARAL-1:0]      ren_id0;
    fl_cnt_t                   fl_count;
    fl_cnt_t                   need_cnt;
    logic                      accept;
    logic                      depart;
    logic                      id1_full_q;
    dec_inst_t [DEC_PARAL-1:0] dec_id1_q;
    ren_t [DEC_PARAL-1:0]      ren_id1_q;
    pc_t                       pc_id1_q;
    logic [DEC_PARAL-1:0]      mask_id1_q;

    // ==================================================
    // id0: decode and rename
    // ==================================================
    for (genvar s = 0; s < DEC_PARAL; s++) begin : g_slot
        inst_decoder inst_decoder_inst (
            .inst_i     (fetch_pkt_i.inst[s]),
            .dec_o      (dec_id0[s])
        );
        assign act_id0[s]        = accept && fetch_pkt_i.avail[s];
        assign pop_id0[s]        = act_id0[s] && dec_id0[s].rd_en;
        assign ren_id0[s].rs1    = rs1_id0[s];
        assign ren_id0[s].rs2    = rs2_id0[s];
        assign ren_id0[s].rd     = dec_id0[s].rd_en ? new_rd_id0[s] : '0;
        assign ren_id0[s].old_rd = dec_id0[s].rd_en ? old_rd_id0[s] : '0;
    end

    // Registers the incoming packet would take.
    always_comb begin
        need_cnt = '0;
        for (int s = 0; s < DEC_PARAL; s++) begin
            need_cnt = need_cnt + fl_cnt_t'(fetch_pkt_i.avail[s] && dec_id0[s].rd_en);
        end
    end

    assign fetch_rdy_o = (!id1_full_q || depart) && (fl_count >= need_cnt);
    assign accept      = fetch_vld_i && fetch_rdy_o;

    rename_map rename_map_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .dec_i      (dec_id0),
        .act_i      (act_id0),
        .phys_rs1_o (rs1_id0),
        .phys_rs2_o (rs2_id0),
        .old_rd_o   (old_rd_id0),
        .new_rd_i   (new_rd_id0)
    );

    free_list free_list_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .pop_i      (pop_id0),
        .pop_idx_o  (new_rd_id0),
        .count_o    (fl_count),
        .commit_i   (commit_i)
    );

    // ==================================================
    // id1 register
    // ==================================================
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id1_full_q <= 1'b0;
        end else if (accept) begin
            id1_full_q <= 1'b1;
        end else if (depart) begin
            id1_full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            dec_id1_q  <= dec_id0;
            ren_id1_q  <= ren_id0;
            pc_id1_q   <= fetch_pkt_i.pc;
            mask_id1_q <= fetch_pkt_i.avail;
        end
    end

    dispatch_ctrl dispatch_ctrl_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .id1_dec_i  (dec_id1_q),
        .id1_phys_i (ren_id1_q),
        .id1_pc_i   (pc_id1_q),
        .id1_mask_i (mask_id1_q),
        .id1_full_i (id1_full_q),
        .alu_pkt_o  (alu_pkt_o),
        .lsu_pkt_o  (lsu_pkt_o),
        .rob_pkt_o  (rob_pkt_o),
        .alu_vld_o  (alu_vld_o),
        .lsu_vld_o  (lsu_vld_o),
        .rob_vld_o  (rob_vld_o),
        .alu_rdy_i  (alu_rdy_i),
        .lsu_rdy_i  (lsu_rdy_i),
        .rob_rdy_i  (rob_rdy_i),
        .depart_o   (depart)
    );

endmodule : decode_stage

//--- verification/decode_stage_tb.sv
`timescale 1ns/10ps
module decode_stage_tb import isa_pkg::*, core_pkg::*; ();

    localparam int CYCLE_LIMIT = 3000;   // About 400 packets at up to 6 cycles, plus margin.

    typedef struct packed {
        issue_pkt_t alu;
        issue_pkt_t lsu;
        rob_pkt_t   rob;
    } exp_pkt_t;

    typedef struct packed {
        unit_e           unit;
        logic [OP_W-1:0] op;
        logic            uses_imm;
        imm_t            imm;
        arch_reg_t       rs1;
        arch_reg_t       rs2;
        arch_reg_t       rd;
        logic            rd_en;
        logic            illegal;
    } ref_dec_t;

    logic       clk_i;
    logic       rst_n_i;
    fetch_pkt_t fetch_pkt_i;
    logic       fetch_vld_i;
    logic       fetch_rdy_o;
    issue_pkt_t alu_pkt_o;
    logic       alu_vld_o;
    logic       alu_rdy_i;
    issue_pkt_t lsu_pkt_o;
    logic       lsu_vld_o;
    logic       lsu_rdy_i;
    rob_pkt_t   rob_pkt_o;
    logic       rob_vld_o;
    logic       rob_rdy_i;
    commit_t    commit_i;

    integer     seed = 32'h54d3;
    string      test_name = "reset";
    int         mismatch_cnt = 0;
    int         failure_cnt = 0;
    int         cycle_cnt = 0;
    int         packets_done = 0;
    int         mix_kind, vld_pct, rdy_pct, commit_pct;
    exp_pkt_t   exp_q[$];
    phys_reg_t  free_q[$];
    phys_reg_t  retire_q[$];
    phys_reg_t  map_ref[ARCH_REGS];
    exp_pkt_t   head = '0;
    pc_t        next_pc = 32'h0000_1000;
    logic       exp_full, exp_depart, exp_fetch_rdy, took_fetch;
    logic       exp_alu_vld, exp_lsu_vld, exp_rob_vld;
    logic       need_alu, need_lsu, need_rob;
    logic       stalled;
    issue_pkt_t alu_seen;
    issue_pkt_t lsu_seen;
    rob_pkt_t   rob_seen;

    decode_stage dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", cycle_cnt);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ==================================================
    // Reference decoder
    // ==================================================
    function automatic logic [OP_W-1:0] alu_op_for(funct3_t f3, logic b30, logic reg_form);
        case (f3)
            3'b000:  return (b30 && reg_form) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return b30 ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic ref_dec_t decode_ref(inst_t inst);
        ref_dec_t d;
        imm_t     i_imm;
        imm_t     s_imm;
        d     = '0;
        i_imm = {{20{inst[31]}}, inst[31:20]};
        s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        case (inst[6:0])
            OPC_OP: begin
                d.unit = UNIT_ALU;
                d.op   = alu_op_for(inst[14:12], inst[30], 1'b1);
                d.rs1  = inst[19:15];
                d.rs2  = inst[24:20];
                d.rd   = inst[11:7];
            end
            OPC_OP_IMM: begin
                d.unit     = UNIT_ALU;
                d.op       = alu_op_for(inst[14:12], inst[30], 1'b0);
                d.uses_imm = 1'b1;
                d.imm      = i_imm;
                d.rs1      = inst[19:15];
                d.rd       = inst[11:7];
            end
            OPC_LOAD: begin
                d.unit     = UNIT_LSU;
                d.op       = {1'b0, inst[14:12]};
                d.uses_imm = 1'b1;
                d.imm      = i_imm;
                d.rs1      = inst[19:15];
                d.rd       = inst[11:7];
            end
            OPC_STORE: begin
                d.unit     = UNIT_LSU;
                d.op       = {1'b1, inst[14:12]};
                d.uses_imm = 1'b1;
                d.imm      = s_imm;
                d.rs1      = inst[19:15];
                d.rs2      = inst[24:20];
            end
            default: d.illegal = 1'b1;
        endcase
        d.rd_en = (d.rd != '0);                 // Stores and illegal ops leave rd at zero.
        return d;
    endfunction

    function automatic issue_pkt_t clear_idle_uops(issue_pkt_t p);
        for (int s = 0; s < DEC_PARAL; s++) begin
            if (!p.mask[s]) p.uop[s] = '0;
        end
        return p;
    endfunction

    function automatic rob_pkt_t clear_idle_entries(rob_pkt_t p);
        for (int s = 0; s < DEC_PARAL; s++) begin
            if (!p.mask[s]) p.entry[s] = '0;
        end
        return p;
    endfunction

    assign alu_seen = clear_idle_uops(alu_pkt_o);
    assign lsu_seen = clear_idle_uops(lsu_pkt_o);
    assign rob_seen = clear_idle_entries(rob_pkt_o);

    // ==================================================
    // Stimulus and model
    // ==================================================
    function automatic bit roll(int pct);
        return int'($unsigned($random(seed)) % 100) < pct;
    endfunction

    // Kind 0 is ALU only, 1 is every class, 2 is ALU with a nonzero rd.
    function automatic inst_t random_inst(int kind);
        inst_t i;
        int    pick;
        i    = $random(seed);
        pick = (kind == 1) ? int'($unsigned($random(seed)) % 5) : int'($unsigned($random(seed)) % 2);
        case (pick)
            0:       i[6:0] = OPC_OP;
            1:       i[6:0] = OPC_OP_IMM;
            2:       i[6:0] = OPC_LOAD;
            3:       i[6:0] = OPC_STORE;
            default: i[6:0] = {i[6:3], 3'b111};  // Bit 2 set is never a legal opcode.
        endcase
        i[11:7]  = 5'($unsigned($random(seed)) % 8);  // Few registers, so bypass hits often.
        i[19:15] = 5'($unsigned($random(seed)) % 8);
        i[24:20] = 5'($unsigned($random(seed)) % 8);
        if (kind == 2) i[11:7] = 5'(1 + $unsigned($random(seed)) % 7);
        return i;
    endfunction

    task automatic rename_packet();
        exp_pkt_t p;
        ref_dec_t d;
        uop_t     u;
        p = '0;
        for (int s = 0; s < DEC_PARAL; s++) begin
            if (fetch_pkt_i.avail[s]) begin
                d          = decode_ref(fetch_pkt_i.inst[s]);
                u          = '0;
                u.op       = d.op;
                u.imm      = d.imm;
                u.uses_imm = d.uses_imm;
                u.rs1      = map_ref[d.rs1];
                u.rs2      = map_ref[d.rs2];
                u.rd_en    = d.rd_en;
                p.rob.mask[s]        = 1'b1;
                p.rob.entry[s].pc    = fetch_pkt_i.pc + pc_t'(4 * s);
                p.rob.entry[s].rd    = d.rd;
                p.rob.entry[s].rd_en = d.rd_en;
                p.rob.entry[s].excp  = d.illegal;
                if (d.rd_en) begin
                    u.rd                   = free_q.pop_front();
                    p.rob.entry[s].prd     = u.rd;
                    p.rob.entry[s].old_prd = map_ref[d.rd];
                    map_ref[d.rd]          = u.rd;   // Later slots see it.
                end
                if (d.unit == UNIT_ALU) begin
                    p.alu.mask[s] = 1'b1;
                    p.alu.uop[s]  = u;
                end else if (d.unit == UNIT_LSU) begin
                    p.lsu.mask[s] = 1'b1;
                    p.lsu.uop[s]  = u;
                end
            end
        end
        exp_q.push_back(p);
    endtask

    // Replays the rising edge that has just passed.
    task automatic apply_edge();
        exp_pkt_t gone;
        took_fetch = fetch_vld_i && exp_fetch_rdy;
        if (exp_depart) begin
            gone = exp_q.pop_front();
            packets_done++;
            for (int s = 0; s < DEC_PARAL; s++) begin
                if (gone.rob.mask[s] && gone.rob.entry[s].rd_en) begin
                    retire_q.push_back(gone.rob.entry[s].old_prd);
                end
            end
        end
        if (took_fetch) rename_packet();
        if (commit_i.vld) free_q.push_back(commit_i.old_prd);   // After this edge's pops.
        exp_full = (exp_q.size() != 0);
        if (exp_full) head = exp_q[0];
    endtask

    task automatic drive_inputs();
        if (!fetch_vld_i || took_fetch || vld_pct == 0) begin
            fetch_vld_i         = roll(vld_pct);
            fetch_pkt_i.pc      = next_pc;
            fetch_pkt_i.avail   = roll(50) ? 2'b11 : (roll(50) ? 2'b01 : 2'b10);
            fetch_pkt_i.inst[0] = random_inst(mix_kind);
            fetch_pkt_i.inst[1] = random_inst(mix_kind);
            next_pc             = next_pc + 32'd8;
        end
        alu_rdy_i = roll(rdy_pct);
        lsu_rdy_i = roll(rdy_pct);
        rob_rdy_i = roll(rdy_pct);
        commit_i  = '0;
        if (retire_q.size() != 0 && roll(commit_pct)) begin
            commit_i.vld     = 1'b1;
            commit_i.old_prd = retire_q.pop_front();
        end
    endtask

    task automatic predict_outputs();
        ref_dec_t d;
        int       need_regs;
        need_alu    = exp_full && (|head.alu.mask);
        need_lsu    = exp_full && (|head.lsu.mask);
        need_rob    = exp_full && (|head.rob.mask);
        exp_alu_vld = need_alu && (!need_lsu || lsu_rdy_i) && (!need_rob || rob_rdy_i);
        exp_lsu_vld = need_lsu && (!need_alu || alu_rdy_i) && (!need_rob || rob_rdy_i);
        exp_rob_vld = need_rob && (!need_alu || alu_rdy_i) && (!need_lsu || lsu_rdy_i);
        exp_depart  = exp_full && (!need_alu || alu_rdy_i) && (!need_lsu || lsu_rdy_i)
                      && (!need_rob || rob_rdy_i);
        need_regs = 0;
        for (int s = 0; s < DEC_PARAL; s++) begin
            d = decode_ref(fetch_pkt_i.inst[s]);
            if (fetch_pkt_i.avail[s] && d.rd_en) need_regs++;
        end
        exp_fetch_rdy = (!exp_full || exp_depart) && (free_q.size() >= need_regs);
    endtask

    task automatic tick();
        @(negedge clk_i);
        apply_edge();
        drive_inputs();
        predict_outputs();
    endtask

    task automatic set_traffic(int kind, int vld, int rdy, int commit);
        mix_kind   = kind;
        vld_pct    = vld;
        rdy_pct    = rdy;
        commit_pct = commit;
    endtask

    task automatic run(string name, int cycles);
        test_name = name;
        repeat (cycles) tick();
    endtask

    task automatic note_mismatch(string what, logic [127:0] exp_v, logic [127:0] act_v);
        mismatch_cnt++;
        $display("mismatch %s %s: expected %h actual %h", test_name, what, exp_v, act_v);
    endtask

    // ==================================================
    // Checks
    // ==================================================
    a_alu_vld: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        alu_vld_o == exp_alu_vld)
        else note_mismatch("alu_vld", $sampled(exp_alu_vld), $sampled(alu_vld_o));
    a_lsu_vld: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        lsu_vld_o == exp_lsu_vld)
        else note_mismatch("lsu_vld", $sampled(exp_lsu_vld), $sampled(lsu_vld_o));
    a_rob_vld: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rob_vld_o == exp_rob_vld)
        else note_mismatch("rob_vld", $sampled(exp_rob_vld), $sampled(rob_vld_o));
    a_fetch_rdy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fetch_rdy_o == exp_fetch_rdy)
        else note_mismatch("fetch_rdy", $sampled(exp_fetch_rdy), $sampled(fetch_rdy_o));

    // Held packets must match on every cycle until they leave.
    a_alu_pkt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        exp_full |-> alu_seen == head.alu)
        else note_mismatch("alu_pkt", $sampled(head.alu), $sampled(alu_seen));
    a_lsu_pkt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        exp_full |-> lsu_seen == head.lsu)
        else note_mismatch("lsu_pkt", $sampled(head.lsu), $sampled(lsu_seen));
    a_rob_pkt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        exp_full |-> rob_seen == head.rob)
        else note_mismatch("rob_pkt", $sampled(head.rob), $sampled(rob_seen));

    initial begin
        rst_n_i       = 1'b0;
        fetch_vld_i   = 1'b0;
        fetch_pkt_i   = '0;
        alu_rdy_i     = 1'b0;
        lsu_rdy_i     = 1'b0;
        rob_rdy_i     = 1'b0;
        commit_i      = '0;
        exp_full      = 1'b0;
        exp_depart    = 1'b0;
        exp_fetch_rdy = 1'b1;
        took_fetch    = 1'b0;
        for (int r = 0; r < ARCH_REGS; r++) map_ref[r] = phys_reg_t'(r);
        for (int r = ARCH_REGS; r < PHYS_REGS; r++) free_q.push_back(phys_reg_t'(r));
        set_traffic(0, 0, 100, 0);
        repeat (16) @(negedge clk_i);
        rst_n_i = 1'b1;
        predict_outputs();

        set_traffic(0, 90, 100, 50);
        run("alu_basic", 100);
        set_traffic(1, 80, 70, 50);
        run("mixed_backpressure", 600);

        // Free list runs dry once commits stop.
        set_traffic(2, 100, 100, 0);
        test_name = "exhaust";
        stalled   = 1'b0;
        for (int c = 0; c < 64 && !stalled; c++) begin
            tick();
            stalled = fetch_vld_i && !exp_fetch_rdy;
        end
        if (!stalled) begin
            failure_cnt++;
            $display("fetch was never stalled after the free registers ran out");
        end
        run("exhaust", 8);
        set_traffic(1, 90, 100, 60);
        run("refill", 200);

        set_traffic(1, 0, 100, 0);
        test_name = "drain";
        for (int c = 0; c < 20 && exp_q.size() != 0; c++) tick();
        if (exp_q.size() != 0) begin
            failure_cnt++;
            $display("a packet was still held in id1 after the drain");
        end
        tick();

        $display("%0d packets checked, %0d mismatches, %0d other failures",
                 packets_done, mismatch_cnt, failure_cnt);
        if (mismatch_cnt == 0 && failure_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : decode_stage_tb

//--- list.f
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/inst_decoder.sv
rtl/rename_map.sv
rtl/free_list.sv
rtl/dispatch_ctrl.sv
rtl/decode_stage.sv
verification/decode_stage_tb.sv
